/* dv/sonar_trace.txt */
// columns (hex): echo delay, echo width (0 = no echo), credit delay,
// expected dist_cm, expected dist_timeout
14  3c  5   a   0
0a  05  3   0   0
1e  06  2   1   0
0f  79  4   14  0
28  00  6   0   1
64  15e 2   0   1
05  12c 320 32  0
0c  2f  320 7   0
08  5a  3   f   0
19  c7  1   21  0
03  0c  2   2   0
3c  00  2   0   1
07  01  1   0   0
32  f0  2   28  0
02  14a 4   37  0
c8  12c 3   0   1

/* filelist.f */
logic/sonar_pkg.sv
logic/meas_if.sv
logic/ranging_fsm.sv
logic/pulse_to_cm.sv
logic/result_queue.sv
logic/sonar_top.sv
dv/tb_sonar.sv

/* Bender.yml */
package:
  name: sonar

sources:
  - logic/sonar_pkg.sv
  - logic/meas_if.sv
  - logic/ranging_fsm.sv
  - logic/pulse_to_cm.sv
  - logic/result_queue.sv
  - logic/sonar_top.sv
  - target: simulation
    files:
      - dv/tb_sonar.sv

/* dv/tb_sonar.sv */
`timescale 1ns/1ps

module tb_sonar
	import sonar_pkg::*;
();

	localparam string TRACE_FILE = "dv/sonar_trace.txt";
	localparam int    MAX_TESTS  = 32;
	localparam int    COLS       = 5;   // delay, width, credit delay, dist, timeout
	localparam int    START_WIN  = 6;   // cycles to look for trig after a start

	logic              CLK;
	logic              RST_N;
	logic              start_n;
	logic              echo;
	logic              dist_credit;
	logic              trig;
	logic              dist_valid;
	logic [DIST_W-1:0] dist_cm;
	logic              dist_timeout;

	logic [15:0] trace [MAX_TESTS*COLS];
	int          n_tests    = 0;
	int          limit      = 0;
	int          cycles     = 0;
	int          errors     = 0;
	int          received   = 0;              // results seen so far
	int          granted    = CONS_CREDITS;   // credits ever given to the queue
	int          trig_rises = 0;
	int          test_errs [MAX_TESTS];

	sonar_top uut (
		.CLK          (CLK),
		.RST_N        (RST_N),
		.start_n      (start_n),
		.echo         (echo),
		.dist_credit  (dist_credit),
		.trig         (trig),
		.dist_valid   (dist_valid),
		.dist_cm      (dist_cm),
		.dist_timeout (dist_timeout)
	);

	initial
	begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;   // 8 ns period
	end

	// --------------------------------------------------
	// error reporting
	// --------------------------------------------------
	task automatic report_mismatch(input int idx, input string sig,
		input logic [31:0] got, input logic [31:0] exp);
		$display("FAIL test %0d %s got 0x%0h expected 0x%0h", idx, sig, got, exp);
		errors++;
		test_errs[idx]++;
	endtask

	task automatic report_error(input int idx, input string msg);
		$display("%s", msg);
		errors++;
		if (idx >= 0)
			test_errs[idx]++;
	endtask

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	// one-cycle low pulse, returns the cycle trig was first seen high, 0 if never
	task automatic request_start(output int rise_at);
		int k;
		rise_at = 0;
		k       = 0;
		start_n = 1'b0;
		while (rise_at == 0 && k < START_WIN)
		begin
			@(negedge CLK);
			start_n = 1'b1;
			k++;
			if (trig)
				rise_at = k;
		end
	endtask

	// echo model, called on the cycle trig is seen low again
	task automatic answer_echo(input int delay, input int width);
		repeat (delay) @(negedge CLK);
		start_n = 1'b0;            // stray start while the fsm waits
		echo    = (width != 0);
		@(negedge CLK);
		start_n = 1'b1;
		if (width > 1)
			repeat (width - 1) @(negedge CLK);
		echo = 1'b0;
	endtask

	initial
	begin : main_flow
		int i;
		int rise_at;
		int high;
		int sum;
		int passed;
		void'($urandom(32'h664d));
		RST_N   = 1'b0;
		start_n = 1'b1;
		echo    = 1'b0;
		for (i = 0; i < MAX_TESTS; i++)
			test_errs[i] = 0;
		$readmemh(TRACE_FILE, trace);
		// list ends at the first missing or zero delay
		while (n_tests < MAX_TESTS && !$isunknown(trace[n_tests*COLS])
			&& trace[n_tests*COLS] != 0)
			n_tests++;
		if (n_tests == 0)
			report_error(-1, "no tests read from the trace file");
		sum = 0;
		for (i = 0; i < n_tests; i++)
			sum += trace[i*COLS] + trace[i*COLS+1] + trace[i*COLS+2];
		limit = sum + n_tests * (ECHO_TIMEOUT + 100) + 2000;   // starts the watchdog

		repeat (10) @(negedge CLK);
		if (trig !== 1'b0 || dist_valid !== 1'b0)
			report_error(-1, "trig or dist_valid not low in reset");
		RST_N = 1'b1;

		for (i = 0; i < n_tests; i++)
		begin
			rise_at = 0;
			while (rise_at == 0)   // stalled chain drops the start, try again
			begin
				repeat ($urandom % 8 + 2) @(negedge CLK);
				request_start(rise_at);
			end
			if (rise_at != 3)
				report_error(i, $sformatf("test %0d: trig rose %0d cycles after start_n, not 3",
					i, rise_at));
			high = 1;
			@(negedge CLK);
			while (trig)
			begin
				high++;
				@(negedge CLK);
			end
			if (high != TRIG_CYCLES)
				report_error(i, $sformatf("test %0d: trig high for %0d cycles, not %0d",
					i, high, TRIG_CYCLES));
			answer_echo(trace[i*COLS], trace[i*COLS+1]);
		end

		wait (received >= n_tests);
		repeat (200) @(negedge CLK);   // room for stray trigs or results
		if (received != n_tests)
			report_error(-1, $sformatf("got %0d results for %0d tests", received, n_tests));
		if (trig_rises != n_tests)
			report_error(-1, $sformatf("trig rose %0d times for %0d tests", trig_rises, n_tests));

		passed = 0;
		for (i = 0; i < n_tests; i++)
			if (test_errs[i] == 0)
				passed++;
		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			n_tests, passed, n_tests - passed, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// --------------------------------------------------
	// monitors, consumer, watchdog
	// --------------------------------------------------
	always @(posedge trig)
		trig_rises++;

	// results in trace order, never past the credits granted
	always @(negedge CLK)
	begin
		if (RST_N && dist_valid)
		begin
			if (received >= n_tests)
				report_error(-1, "dist_valid pulsed with no test left to match");
			else
			begin
				if (received >= granted)
					report_error(received, $sformatf("test %0d: dist_valid without a credit",
						received));
				if (dist_cm !== trace[received*COLS+3])
					report_mismatch(received, "dist_cm", dist_cm, trace[received*COLS+3]);
				if (dist_timeout !== trace[received*COLS+4][0])
					report_mismatch(received, "dist_timeout", dist_timeout,
						trace[received*COLS+4][0]);
				$display("test %0d done: %0d cm, timeout %0b, %0d errors",
					received, dist_cm, dist_timeout, test_errs[received]);
			end
			received <= received + 1;
		end
	end

	// one credit back per result, after that test's delay
	initial
	begin : consumer_credits
		int k;
		dist_credit = 1'b0;
		wait (limit > 0);
		for (k = 0; k < n_tests; k++)
		begin
			wait (received > k);
			repeat (trace[k*COLS+2]) @(negedge CLK);
			dist_credit = 1'b1;
			@(negedge CLK);
			dist_credit = 1'b0;
			granted <= granted + 1;   // usable from the next pop on
		end
	end

	initial
	begin : watchdog
		wait (limit > 0);
		while (cycles < limit)
		begin
			@(posedge CLK);
			cycles++;
		end
		$display("run hung after %0d cycles with %0d of %0d results", cycles, received, n_tests);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* logic/sonar_top.sv */
`timescale 1ns/1ps

module sonar_top
	import sonar_pkg::*;
(
	input  logic              CLK,
	input  logic              RST_N,
	input  logic              start_n,       // low requests one measurement
	input  logic              echo,          // sensor echo pin
	input  logic              dist_credit,   // consumer credit return
	output logic              trig,          // sensor trig pin
	output logic              dist_valid,
	output logic [DIST_W-1:0] dist_cm,
	output logic              dist_timeout
);

	// --------------------------------------------------
	// converter to queue
	// --------------------------------------------------
	logic              push;
	logic              push_timeout;
	logic [DIST_W-1:0] push_dist;
	logic              full;

	meas_if u_meas ();   // fsm to converter, one credit deep

	ranging_fsm u_ranging_fsm (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.start_n (start_n),
		.echo    (echo),
		.trig    (trig),
		.meas    (u_meas)
	);

	pulse_to_cm u_pulse_to_cm (
		.CLK          (CLK),
		.RST_N        (RST_N),
		.full         (full),
		.meas         (u_meas),
		.push         (push),
		.push_timeout (push_timeout),
		.push_dist    (push_dist)
	);

	result_queue u_result_queue (
		.CLK          (CLK),
		.RST_N        (RST_N),
		.push         (push),
		.push_timeout (push_timeout),
		.push_dist    (push_dist),
		.dist_credit  (dist_credit),
		.full         (full),
		.dist_valid   (dist_valid),
		.dist_cm      (dist_cm),
		.dist_timeout (dist_timeout)
	);

endmodule

/* logic/result_queue.sv */
`timescale 1ns/1ps

module result_queue
	import sonar_pkg::*;
(
	input  logic              CLK,
	input  logic              RST_N,
	input  logic              push,
	input  logic              push_timeout,
	input  logic [DIST_W-1:0] push_dist,
	input  logic              dist_credit,   // pulse from the consumer
	output logic              full,
	output logic              dist_valid,
	output logic [DIST_W-1:0] dist_cm,
	output logic              dist_timeout
);

	logic [DIST_W:0]   mem [QUEUE_DEPTH];   // {timeout, dist}
	logic [QPTR_W-1:0] wr_ptr;
	logic [QPTR_W-1:0] rd_ptr;
	logic [QCNT_W-1:0] count;
	logic [CRED_W-1:0] credits;             // consumer credits left
	logic              pop;

	assign full = (count == QCNT_W'(QUEUE_DEPTH));
	// pop whenever there is data and the consumer can take it
	assign pop  = (count != '0) && (credits != '0);

	// --------------------------------------------------
	// storage and output register
	// --------------------------------------------------
	always_ff @(posedge CLK)
	begin
		if (push)
			mem[wr_ptr] <= {push_timeout, push_dist};
		if (pop)
			{dist_timeout, dist_cm} <= mem[rd_ptr];
	end

	// --------------------------------------------------
	// pointers, fill level, credits
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			credits    <= CRED_W'(CONS_CREDITS);
			dist_valid <= 1'b0;
		end
		else
		begin
			dist_valid <= pop;
			if (push)
				wr_ptr <= (wr_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // both or neither
			endcase
			// spend on pop, refund on consumer pulse, same cycle is net zero
			credits <= credits - CRED_W'(pop) + CRED_W'(dist_credit);
		end
	end

	a_no_push_full: assert property (@(posedge CLK) disable iff (!RST_N)
		push |-> !full)
		else $error("push into a full result queue");

	// a consumer returning more than it was given breaks the count
	a_credit_max: assert property (@(posedge CLK) disable iff (!RST_N)
		credits <= CRED_W'(CONS_CREDITS))
		else $error("consumer credit count above limit");

endmodule

/* logic/pulse_to_cm.sv */
`timescale 1ns/1ps

module pulse_to_cm
	import sonar_pkg::*;
(
	input  logic              CLK,
	input  logic              RST_N,
	input  logic              full,          // queue back-pressure
	meas_if.dst               meas,
	output logic              push,
	output logic              push_timeout,
	output logic [DIST_W-1:0] push_dist
);

	logic              holding;   // a measurement is latched
	logic [ECHO_W-1:0] rem;       // cycles left to divide
	logic [DIST_W-1:0] quot;      // whole cm so far
	logic              tmo;
	logic              done;

	// --------------------------------------------------
	// divide by repeated subtraction
	// --------------------------------------------------
	// done once the remainder drops below one cm
	assign done = holding && (rem < ECHO_W'(CYCLES_PER_CM));

	always_ff @(posedge CLK)
	begin
		if (meas.valid)
		begin
			rem  <= meas.timed_out ? '0 : meas.echo_cycles;   // timeout gives 0 cm
			quot <= '0;
			tmo  <= meas.timed_out;
		end
		else if (holding && !done)
		begin
			rem  <= rem - ECHO_W'(CYCLES_PER_CM);
			quot <= quot + 1'b1;
		end
	end

	// --------------------------------------------------
	// hand off to the queue
	// --------------------------------------------------
	assign push         = done && !full;   // result held while full
	assign push_dist    = quot;
	assign push_timeout = tmo;

	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			holding     <= 1'b0;
			meas.credit <= 1'b0;
		end
		else
		begin
			meas.credit <= push;   // credit back the cycle after the push
			if (meas.valid)
				holding <= 1'b1;
			else if (push)
				holding <= 1'b0;
		end
	end

	// the fsm waits for the credit, so nothing lands on a held result
	a_no_overrun: assert property (@(posedge CLK) disable iff (!RST_N)
		meas.valid |-> !holding)
		else $error("new measurement while one is still held");

endmodule

/* logic/ranging_fsm.sv */
`timescale 1ns/1ps

module ranging_fsm
	import sonar_pkg::*;
(
	input  logic CLK,
	input  logic RST_N,
	input  logic start_n,   // async low request for a measurement
	input  logic echo,      // async echo from the sensor
	output logic trig,
	meas_if.src  meas
);

	logic                  start_s1;
	logic                  start_s2;
	logic                  echo_s1;
	logic                  echo_s2;
	logic                  echo_d;       // previous synced echo for fall detect
	logic [1:0]            state;
	logic [1:0]            state_nxt;
	logic [TRIG_CNT_W-1:0] trig_cnt;
	logic [ECHO_W-1:0]     echo_cnt;     // saturating echo-high cycle count
	logic [ECHO_W-1:0]     wait_cnt;     // all cycles spent in wait
	logic                  have_credit;
	logic                  start_req;
	logic                  echo_fall;
	logic                  wait_over;
	logic                  send;

	// --------------------------------------------------
	// two-flop synchronizers
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			start_s1 <= 1'b1;   // idle level of start_n
			start_s2 <= 1'b1;
			echo_s1  <= 1'b0;
			echo_s2  <= 1'b0;
			echo_d   <= 1'b0;
		end
		else
		begin
			start_s1 <= start_n;
			start_s2 <= start_s1;
			echo_s1  <= echo;
			echo_s2  <= echo_s1;
			echo_d   <= echo_s2;
		end
	end

	// start only counts in idle with the credit and is never stored
	assign start_req = (state == ST_IDLE) && !start_s2 && have_credit;
	assign echo_fall = echo_d && !echo_s2;
	// two extra cycles cover the echo synchronizer
	assign wait_over = (wait_cnt == ECHO_W'(ECHO_TIMEOUT + 1));
	assign send      = (state == ST_WAIT) && (echo_fall || wait_over);

	// --------------------------------------------------
	// state machine
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_IDLE:
				if (start_req)
					state_nxt = ST_TRIG;
			ST_TRIG:
				if (trig_cnt == TRIG_CNT_W'(TRIG_CYCLES - 1))
					state_nxt = ST_WAIT;
			ST_WAIT:
				if (echo_fall || wait_over)
					state_nxt = ST_IDLE;
			default:
				state_nxt = ST_IDLE;
		endcase
	end

	assign trig = (state == ST_TRIG);

	// trig width and echo counters
	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			trig_cnt <= '0;
			echo_cnt <= '0;
			wait_cnt <= '0;
		end
		else
		begin
			if (state == ST_TRIG)
				trig_cnt <= trig_cnt + 1'b1;
			else
				trig_cnt <= '0;
			if (state == ST_WAIT)
			begin
				wait_cnt <= wait_cnt + 1'b1;
				if (echo_s2 && echo_cnt != '1)   // stick at the top
					echo_cnt <= echo_cnt + 1'b1;
			end
			else
			begin
				wait_cnt <= '0;
				echo_cnt <= '0;
			end
		end
	end

	// --------------------------------------------------
	// measurement out and credit handling
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			meas.valid  <= 1'b0;
			have_credit <= 1'b1;   // converter starts empty
		end
		else
		begin
			meas.valid <= send;
			if (send)
				have_credit <= 1'b0;
			else if (meas.credit)
				have_credit <= 1'b1;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (send)
		begin
			meas.timed_out   <= !echo_fall;                 // fall wins a tie
			meas.echo_cycles <= echo_fall ? echo_cnt : '0;
		end
	end

	// trig is one clean pulse of the full width
	a_trig_width: assert property (@(posedge CLK) disable iff (!RST_N)
		$rose(trig) |-> trig [*TRIG_CYCLES] ##1 !trig)
		else $error("trig pulse width wrong");

	a_valid_credit: assert property (@(posedge CLK) disable iff (!RST_N)
		meas.valid |-> $past(have_credit))
		else $error("measurement sent without credit");

endmodule

/* logic/meas_if.sv */
`timescale 1ns/1ps

// one raw echo measurement from the ranging fsm to the converter,
// plus the single credit that comes back once it is queued
interface meas_if
	import sonar_pkg::*;
();

	logic              valid;        // one-cycle pulse
	logic [ECHO_W-1:0] echo_cycles;  // echo-high cycles
	logic              timed_out;    // echo missing or too long
	logic              credit;       // one-cycle pulse back to src

	modport src (
		output valid,
		output echo_cycles,
		output timed_out,
		input  credit
	);

	modport dst (
		input  valid,
		input  echo_cycles,
		input  timed_out,
		output credit
	);

endinterface

/* logic/sonar_pkg.sv */
package sonar_pkg;

	// --------------------------------------------------
	// timing, scaled down for simulation
	// --------------------------------------------------
	// a real board at 50 MHz wants ~500 trig cycles and ~2900 per cm
	localparam int TRIG_CYCLES   = 10;   // trig pulse width
	localparam int CYCLES_PER_CM = 6;    // echo-high cycles per cm
	localparam int ECHO_TIMEOUT  = 400;  // max wait for echo rise and fall

	// --------------------------------------------------
	// widths and sizes
	// --------------------------------------------------
	localparam int ECHO_W       = 16;    // echo cycle count
	localparam int DIST_W       = 16;    // distance in cm
	localparam int QUEUE_DEPTH  = 4;     // result fifo entries
	localparam int CONS_CREDITS = 2;     // consumer credits at reset

	// derived counter widths
	localparam int TRIG_CNT_W = $clog2(TRIG_CYCLES);
	localparam int QPTR_W     = $clog2(QUEUE_DEPTH);
	localparam int QCNT_W     = $clog2(QUEUE_DEPTH + 1);   // holds 0..depth
	localparam int CRED_W     = $clog2(CONS_CREDITS + 1);  // holds 0..credits

	// ranging fsm state codes
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_TRIG = 2'd1;
	localparam logic [1:0] ST_WAIT = 2'd2;

endpackage
